// File: axi_bus.sv
`timescale 1ns/100ps

module axi_bus #(
    parameter bus_pkg::window_t MEM_WINDOW = 0,
    parameter bus_pkg::window_t DDS_WINDOW = 4
) (
    input  logic                clk,
    input  logic                rst,

    input  bus_pkg::bus_req_t   req,
    input  logic                req_valid,
    output logic                req_ready,

    output bus_pkg::bus_rsp_t   rsp,
    output logic                rsp_valid,
    input  logic                rsp_ready,

    output bus_pkg::bus_req_t   slv_req,
    output logic                mem_sel,
    output logic                dds_sel,
    input  bus_pkg::bus_rsp_t   mem_rsp,
    input  bus_pkg::bus_rsp_t   dds_rsp,

    output bus_pkg::bus_stat_t  stat
);

    logic             busy;
    logic             accept;
    logic             rsp_fire;
    logic             unmapped;   // no slave behind this window
    logic             rsp_stage;  // slave answer is on slv_rsp now
    bus_pkg::window_t req_win;
    bus_pkg::window_t cur_win;
    bus_pkg::bus_rsp_t sel_rsp;

    assign req_win   = req.addr[bus_pkg::WIN_LSB +: 4];
    assign cur_win   = slv_req.addr[bus_pkg::WIN_LSB +: 4];

    assign req_ready = ~busy;       // one transfer in flight at most
    assign accept    = req_valid & req_ready;
    assign rsp_fire  = rsp_valid & rsp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (rsp_fire) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slv_req <= req;
        end
    end

    // one-cycle strobes, the cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_sel  <= 1'b0;
            dds_sel  <= 1'b0;
            unmapped <= 1'b0;
        end else begin
            mem_sel  <= accept && (req_win == MEM_WINDOW);
            dds_sel  <= accept && (req_win == DDS_WINDOW);
            unmapped <= accept && (req_win != MEM_WINDOW) && (req_win != DDS_WINDOW);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_stage <= 1'b0;
        end else begin
            rsp_stage <= mem_sel | dds_sel | unmapped;
        end
    end

    // route by the window of the held request
    always_comb begin
        if (cur_win == MEM_WINDOW) begin
            sel_rsp = mem_rsp;
        end else if (cur_win == DDS_WINDOW) begin
            sel_rsp = dds_rsp;
        end else begin
            sel_rsp.data = '0;
            sel_rsp.resp = bus_pkg::RESP_DECERR;
            sel_rsp.id   = slv_req.id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (rsp_stage) begin
            rsp_valid <= 1'b1;
        end else if (rsp_fire) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_stage) begin
            rsp <= sel_rsp;     // held until rsp_ready
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stat <= '0;
        end else if (rsp_fire) begin
            stat.xfer_cnt <= stat.xfer_cnt + 8'd1;
            if (rsp.resp != bus_pkg::RESP_OKAY) begin
                stat.err_cnt <= stat.err_cnt + 8'd1;
            end
        end
    end

endmodule

// File: bus_pkg.sv
package bus_pkg;

    // meaningful widths
    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;   // one bit per byte lane
    typedef logic [1:0]  id_t;     // echoed back in the response
    typedef logic [1:0]  resp_t;
    typedef logic [3:0]  window_t; // top four address bits
    typedef logic [7:0]  cnt_t;

    localparam int WIN_LSB = 28;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    localparam int LED_W = 8;

    // master -> bus, bus -> slaves
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t data;
        strb_t strb;
        id_t   id;
    } bus_req_t;

    // slave -> bus, bus -> master
    typedef struct packed {
        data_t data;
        resp_t resp;
        id_t   id;
    } bus_rsp_t;

    typedef struct packed {
        cnt_t xfer_cnt; // completed transfers
        cnt_t err_cnt;  // error responses
    } bus_stat_t;

endpackage

// File: dds_slave.sv
`timescale 1ns/100ps

module dds_slave #(
    parameter int WAVE_W = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               sel,
    input  bus_pkg::bus_req_t  slv_req,
    output bus_pkg::bus_rsp_t  slv_rsp,
    output logic [WAVE_W-1:0]  wave_out
);

    localparam logic [1:0] REG_FREQ  = 2'd0; // 0x0
    localparam logic [1:0] REG_EN    = 2'd1; // 0x4
    localparam logic [1:0] REG_PHASE = 2'd2; // 0x8, read only

    bus_pkg::data_t freq;
    bus_pkg::data_t phase;
    bus_pkg::data_t rd_data;
    logic           enable;
    logic [1:0]     reg_sel;

    assign reg_sel = slv_req.addr[3:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            freq   <= '0;
            enable <= 1'b0;
        end else if (sel && slv_req.write) begin
            if (reg_sel == REG_FREQ) begin
                for (int b = 0; b < 4; b++) begin
                    if (slv_req.strb[b]) begin
                        freq[8*b +: 8] <= slv_req.data[8*b +: 8];
                    end
                end
            end else if (reg_sel == REG_EN && slv_req.strb[0]) begin
                enable <= slv_req.data[0];
            end
        end
    end

    // phase accumulator
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else if (enable) begin
            phase <= phase + freq;
        end
    end

    assign wave_out = phase[31 -: WAVE_W];

    always_comb begin
        case (reg_sel)
            REG_FREQ:  rd_data = freq;
            REG_EN:    rd_data = {31'b0, enable};
            REG_PHASE: rd_data = phase;
            default:   rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slv_rsp <= '0;
        end else if (sel) begin
            slv_rsp.resp <= bus_pkg::RESP_OKAY;
            slv_rsp.id   <= slv_req.id;
            slv_rsp.data <= slv_req.write ? '0 : rd_data;
        end
    end

endmodule

// File: led_status.sv
`timescale 1ns/100ps

module led_status #(
    parameter int NUM_PAGES = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [1:0]                  btn,
    input  bus_pkg::bus_stat_t          stat,
    input  logic [7:0]                  wave,
    input  bus_pkg::bus_rsp_t           rsp,
    input  logic                        rsp_fire,
    output logic [bus_pkg::LED_W-1:0]   led8,
    output logic [3:0]                  led4
);

    localparam int PW = $clog2(NUM_PAGES);

    logic [1:0]          btn_s;     // synchronizer
    logic [1:0]          btn_d;
    logic [1:0]          btn_rise;
    logic [PW-1:0]       page;
    logic [7:0]          last_rd;
    logic [bus_pkg::LED_W-1:0] page_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_s <= '0;
            btn_d <= '0;
        end else begin
            btn_s <= btn;
            btn_d <= btn_s;
        end
    end

    assign btn_rise = btn_s & ~btn_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            page <= '0;
        end else if (btn_rise[0]) begin
            page <= (page == PW'(NUM_PAGES - 1)) ? '0 : page + 1'b1;
        end else if (btn_rise[1]) begin
            page <= (page == '0) ? PW'(NUM_PAGES - 1) : page - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_rd <= '0;
        end else if (rsp_fire) begin
            last_rd <= rsp.data[7:0];
        end
    end

    always_comb begin
        case (page)
            0:       page_byte = stat.xfer_cnt;
            1:       page_byte = stat.err_cnt;
            2:       page_byte = wave;
            3:       page_byte = last_rd;
            default: page_byte = '0;
        endcase
    end

    assign led8 = ~page_byte;   // active low bar
    assign led4 = 4'(page);

endmodule

// File: ram_slave.sv
`timescale 1ns/100ps

module ram_slave #(
    parameter int MEM_WORDS = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               sel,
    input  bus_pkg::bus_req_t  slv_req,
    output bus_pkg::bus_rsp_t  slv_rsp
);

    localparam int AW = $clog2(MEM_WORDS);

    bus_pkg::data_t mem [MEM_WORDS];
    logic [AW-1:0]  idx;

    // word index, aliases inside the window
    assign idx = slv_req.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (sel && slv_req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (slv_req.strb[b]) begin
                    mem[idx][8*b +: 8] <= slv_req.data[8*b +: 8];
                end
            end
        end
    end

    // answer one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            slv_rsp <= '0;
        end else if (sel) begin
            slv_rsp.resp <= bus_pkg::RESP_OKAY;
            slv_rsp.id   <= slv_req.id;
            if (slv_req.write) begin
                slv_rsp.data <= '0;
            end else begin
                slv_rsp.data <= mem[idx];
            end
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_bus -f sim.f -o tb_soc_bus
./obj_dir/tb_soc_bus +verilator+error+limit+1000 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: sim.f
bus_pkg.sv
axi_bus.sv
ram_slave.sv
dds_slave.sv
led_status.sv
soc_bus_top.sv
soc_bus_checker.sv
tb_soc_bus.sv

// File: soc_bus_checker.sv
`timescale 1ns/100ps

module soc_bus_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    input  logic               req_ready,
    input  bus_pkg::bus_rsp_t  rsp,
    input  logic               rsp_valid,
    input  logic               rsp_ready
);

    int   fail_cnt = 0;
    logic accept;
    logic pending;  // request taken, response not yet accepted

    assign accept = req_valid & req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (rsp_valid && rsp_ready) begin
            pending <= 1'b0;
        end
    end

    // accepted at edge N, rsp_valid set by edge N+2 and not before
    latency_n2: assert property (@(posedge clk) disable iff (rst)
        $past(accept, 3) |-> rsp_valid && !$past(rsp_valid))
    else begin
        fail_cnt++;
        $error("response did not rise exactly two edges after acceptance");
    end

    ready_low: assert property (@(posedge clk) disable iff (rst)
        pending |-> !req_ready)
    else begin
        fail_cnt++;
        $error("req_ready high while a transfer is outstanding");
    end

    rsp_held: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
        fail_cnt++;
        $error("response changed or dropped while rsp_ready was low");
    end

    reset_state: assert property (@(posedge clk)
        rst |=> !rsp_valid && req_ready)
    else begin
        fail_cnt++;
        $error("bus not idle in the cycle after reset");
    end

endmodule

bind soc_bus_top soc_bus_checker u_checker (
    .clk       (clk      ),
    .rst       (rst      ),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp      ),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
);

// File: soc_bus_top.sv
`timescale 1ns/100ps

module soc_bus_top #(
    parameter bus_pkg::window_t MEM_WINDOW = 0,
    parameter bus_pkg::window_t DDS_WINDOW = 4,
    parameter int               MEM_WORDS  = 64,
    parameter int               WAVE_W     = 8,
    parameter int               NUM_PAGES  = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  bus_pkg::bus_req_t           req,
    input  logic                        req_valid,
    output logic                        req_ready,
    output bus_pkg::bus_rsp_t           rsp,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    input  logic [1:0]                  btn,
    output logic [WAVE_W-1:0]           da_data,
    output logic [bus_pkg::LED_W-1:0]   led8,
    output logic [3:0]                  led4
);

    bus_pkg::bus_req_t  slv_req;
    bus_pkg::bus_rsp_t  mem_rsp;
    bus_pkg::bus_rsp_t  dds_rsp;
    bus_pkg::bus_stat_t stat;
    logic               mem_sel;
    logic               dds_sel;
    logic               rsp_fire;

    // slv_req stays put until the next accept, so its write flag tags the response
    assign rsp_fire = rsp_valid & rsp_ready & ~slv_req.write;

    axi_bus #(
        .MEM_WINDOW (MEM_WINDOW),
        .DDS_WINDOW (DDS_WINDOW)
    ) u_axi_bus (
        .clk       (clk      ),
        .rst       (rst      ),
        .req       (req      ),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp      ),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .slv_req   (slv_req  ),
        .mem_sel   (mem_sel  ),
        .dds_sel   (dds_sel  ),
        .mem_rsp   (mem_rsp  ),
        .dds_rsp   (dds_rsp  ),
        .stat      (stat     )
    );

    ram_slave #(.MEM_WORDS(MEM_WORDS)) u_ram_slave (
        .clk     (clk    ),
        .rst     (rst    ),
        .sel     (mem_sel),
        .slv_req (slv_req),
        .slv_rsp (mem_rsp)
    );

    dds_slave #(.WAVE_W(WAVE_W)) u_dds_slave (
        .clk      (clk    ),
        .rst      (rst    ),
        .sel      (dds_sel),
        .slv_req  (slv_req),
        .slv_rsp  (dds_rsp),
        .wave_out (da_data)
    );

    led_status #(.NUM_PAGES(NUM_PAGES)) u_led_status (
        .clk      (clk     ),
        .rst      (rst     ),
        .btn      (btn     ),
        .stat     (stat    ),
        .wave     (da_data ),
        .rsp      (rsp     ),
        .rsp_fire (rsp_fire),
        .led8     (led8    ),
        .led4     (led4    )
    );

endmodule

// File: tb_soc_bus.sv
`timescale 1ns/100ps

module tb_soc_bus;

    localparam int MEM_WORDS = 64;
    localparam int TIMEOUT   = 50;  // cycles per wait

    logic               clk;
    logic               rst;
    bus_pkg::bus_req_t  req;
    logic               req_valid;
    logic               req_ready;
    bus_pkg::bus_rsp_t  rsp;
    logic               rsp_valid;
    logic               rsp_ready;
    logic [1:0]         btn;
    logic [7:0]         da_data;
    logic [7:0]         led8;
    logic [3:0]         led4;

    bus_pkg::data_t     model [MEM_WORDS];
    int                 errors   = 0;
    int                 timeouts = 0;
    logic [7:0]         exp_xfer = 0;
    logic [7:0]         exp_err  = 0;
    logic [7:0]         exp_last = 0;   // low byte of last read response

    soc_bus_top #(.MEM_WORDS(MEM_WORDS)) i_soc_bus_top (
        .clk       (clk      ),
        .rst       (rst      ),
        .req       (req      ),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp      ),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .btn       (btn      ),
        .da_data   (da_data  ),
        .led8      (led8     ),
        .led4      (led4     )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        assert (actv === expv) else begin
            errors++;
            $display("error at %0t: %s expected %h actual %h", $time, name, expv, actv);
        end
    endtask

    function automatic bus_pkg::data_t apply_strobes(input bus_pkg::data_t old,
            input bus_pkg::data_t d, input bus_pkg::strb_t s);
        bus_pkg::data_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) r[8*b +: 8] = d[8*b +: 8];
        end
        return r;
    endfunction

    function automatic logic [7:0] expected_page_byte(input int p);
        case (p)
            0:       return exp_xfer;
            1:       return exp_err;
            default: return exp_last;
        endcase
    endfunction

    // one transfer, called and returning on a falling edge
    task automatic xfer(input logic wr, input bus_pkg::addr_t a, input bus_pkg::data_t d,
                        input bus_pkg::strb_t s, input bus_pkg::data_t exp_d,
                        input bus_pkg::data_t mask, input bus_pkg::resp_t exp_r);
        bus_pkg::id_t      id;
        bus_pkg::bus_rsp_t got;
        int                n;
        logic              seen;
        id = 2'($urandom);
        req = '{write: wr, addr: a, data: d, strb: s, id: id};
        req_valid = 1'b1;
        n = 0;
        while (!req_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            timeouts++;
            $display("timeout: request at address %h was never accepted", a);
        end
        @(negedge clk);     // taken on the edge just passed
        req_valid = 1'b0;
        seen = 1'b0;
        got = '0;
        n = 0;
        while (!seen && n < TIMEOUT) begin
            rsp_ready = ($urandom % 3) != 0;    // random stalls
            if (rsp_valid && rsp_ready) begin
                got  = rsp;
                seen = 1'b1;
            end
            @(negedge clk);
            n++;
        end
        rsp_ready = 1'b0;
        if (!seen) begin
            timeouts++;
            $display("timeout: no response for address %h", a);
        end
        check_value("rsp.resp", 32'(exp_r), 32'(got.resp));
        check_value("rsp.id", 32'(id), 32'(got.id));
        check_value("rsp.data", exp_d & mask, got.data & mask);
        exp_xfer++;
        if (exp_r == bus_pkg::RESP_DECERR) exp_err++;
        if (!wr) exp_last = exp_d[7:0];
    endtask

    task automatic press(input int b, input int exp_page);
        logic [7:0] pb;
        pb = ~expected_page_byte(exp_page);
        btn[b] = 1'b1;
        repeat (2) @(negedge clk);  // synchronizer plus page register
        check_value("led4", 32'(exp_page), {28'b0, led4});
        if (exp_page != 2) check_value("led8", {24'b0, pb}, {24'b0, led8});
        btn[b] = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        bus_pkg::addr_t a;
        bus_pkg::data_t d;
        bus_pkg::strb_t s;
        int             k;
        int             win;
        int             page;
        logic [7:0]     prev;
        void'($urandom(3757));
        rst = 1'b1;
        req = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        btn = 2'b00;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // fill every word, then random strobed writes anywhere in window 0
        for (int i = 0; i < MEM_WORDS + 40; i++) begin
            a = (i < MEM_WORDS) ? 32'(i) << 2 : {4'h0, 26'($urandom), 2'b00};
            s = (i < MEM_WORDS) ? 4'hf : 4'($urandom);
            d = $urandom;
            model[(a >> 2) % MEM_WORDS] = apply_strobes(model[(a >> 2) % MEM_WORDS], d, s);
            xfer(1'b1, a, d, s, '0, '1, bus_pkg::RESP_OKAY);
        end
        for (int i = 0; i < 40; i++) begin
            a = {4'h0, 26'($urandom), 2'b00};
            xfer(1'b0, a, '0, '0, model[(a >> 2) % MEM_WORDS], '1, bus_pkg::RESP_OKAY);
        end

        // unmapped windows, memory must stay untouched
        for (int i = 0; i < 12; i++) begin
            win = ($urandom % 2) ? $urandom_range(1, 3) : $urandom_range(5, 15);
            a = {4'(win), 26'($urandom), 2'b00};
            xfer(1'b1, a, $urandom, 4'hf, '0, '1, bus_pkg::RESP_DECERR);
            xfer(1'b0, a, '0, '0, '0, '1, bus_pkg::RESP_DECERR);
            a[31:28] = 4'h0;
            xfer(1'b0, a, '0, '0, model[(a >> 2) % MEM_WORDS], '1, bus_pkg::RESP_OKAY);
        end

        // waveform slave
        k = $urandom_range(1, 255);
        xfer(1'b1, 32'h4000_0000, 32'(k) << 24, 4'hf, '0, '1, bus_pkg::RESP_OKAY);
        xfer(1'b1, 32'h4000_0004, 32'h1, 4'hf, '0, '1, bus_pkg::RESP_OKAY);
        for (int i = 0; i < 8; i++) begin
            prev = da_data;
            @(negedge clk);
            check_value("da_data", {24'b0, 8'(prev + 8'(k))}, {24'b0, da_data});
        end
        xfer(1'b1, 32'h4000_0004, 32'h0, 4'hf, '0, '1, bus_pkg::RESP_OKAY);
        prev = da_data;
        repeat (4) @(negedge clk);
        check_value("da_data", {24'b0, prev}, {24'b0, da_data});
        // low 24 phase bits stay zero with this frequency
        xfer(1'b0, 32'h4000_0008, '0, '0, '0, 32'h00ff_ffff, bus_pkg::RESP_OKAY);
        xfer(1'b0, 32'h4000_0000, '0, '0, 32'(k) << 24, '1, bus_pkg::RESP_OKAY);

        // page 3 keeps this read byte through the write after it
        a = 32'h0000_0020;
        d = 32'h5a5a_5ac3;
        model[(a >> 2) % MEM_WORDS] = d;
        xfer(1'b1, a, d, 4'hf, '0, '1, bus_pkg::RESP_OKAY);
        xfer(1'b0, a, '0, '0, model[(a >> 2) % MEM_WORDS], '1, bus_pkg::RESP_OKAY);
        xfer(1'b1, a, ~d, 4'h0, '0, '1, bus_pkg::RESP_OKAY);

        // led pages, four steps up then two down
        check_value("led8", {24'b0, ~exp_xfer}, {24'b0, led8});
        page = 0;
        for (int i = 0; i < 6; i++) begin
            page = (i < 4) ? (page + 1) % 4 : (page + 3) % 4;
            press((i < 4) ? 0 : 1, page);
        end

        $display("errors: %0d value, %0d timeout, %0d assertion", errors, timeouts,
                 i_soc_bus_top.u_checker.fail_cnt);
        if (errors == 0 && timeouts == 0 && i_soc_bus_top.u_checker.fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
